// File: files.f
+incdir+include
rtl/apb8_pkg.sv
rtl/apb8_if.sv
rtl/apb8_decoder.sv
rtl/gpio_port.sv
rtl/uart_tx_regs.sv
rtl/uart_baud_timer.sv
rtl/uart_tx_fsm.sv
rtl/apb8_slaves.sv
test/tb_apb8_slaves.sv

// File: include/apb8_defs.svh
// Bus widths for the 8-bit APB peripheral subsystem
// Address map of the GPIO and UART windows
// Reset values of the peripheral registers

`ifndef APB8_DEFS_SVH
`define APB8_DEFS_SVH

// Bus widths
`define APB8_ADDR_W 8
`define APB8_DATA_W 8
`define APB8_STRB_W (`APB8_DATA_W / 8)

// Offset bits passed to the slaves
`define APB8_OFFS_W 3

// Address map, base and window size in bytes
`define APB8_GPIO_BASE 8'h00
`define APB8_GPIO_SIZE 8'd16
`define APB8_UART_BASE 8'h10
`define APB8_UART_SIZE 8'd8

// Register reset values
`define APB8_GPIO_RST     8'h00
`define APB8_UART_DIV_RST 8'd16

`endif

// File: rtl/apb8_decoder.sv
// APB address decoder for the GPIO and UART windows
// Select fan-out with write strobe qualification
// Response mux and error responder for unmapped addresses

`include "apb8_defs.svh"

module apb8_decoder (
  input  logic                    PCLK,
  input  logic                    reset_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`APB8_ADDR_W-1:0] paddr_i,
  input  logic [`APB8_DATA_W-1:0] pwdata_i,
  input  logic [`APB8_STRB_W-1:0] pstrb_i,
  output logic [`APB8_DATA_W-1:0] prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  apb8_if.dec                     gpio_bus,
  apb8_if.dec                     uart_bus
);
  import apb8_pkg::*;

  // Window masks, upper bits compared against the base
  localparam logic [`APB8_ADDR_W-1:0] GPIO_MASK = ~(`APB8_GPIO_SIZE - 8'd1);
  localparam logic [`APB8_ADDR_W-1:0] UART_MASK = ~(`APB8_UART_SIZE - 8'd1);

  apb8_region_e region;
  logic         wr_qual;
  logic         err_q;

  ////////////////////////////////////////////////////////////
  // Region decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    if ((paddr_i & GPIO_MASK) == `APB8_GPIO_BASE) begin
      region = REGION_GPIO;
    end else if ((paddr_i & UART_MASK) == `APB8_UART_BASE) begin
      region = REGION_UART;
    end else begin
      region = REGION_NONE;
    end
  end

  // Strobe low turns the write into a harmless read
  assign wr_qual = pwrite_i & pstrb_i[0];

  // Fan-out, only psel is region specific
  assign gpio_bus.psel    = psel_i & (region == REGION_GPIO);
  assign gpio_bus.penable = penable_i;
  assign gpio_bus.pwrite  = wr_qual;
  assign gpio_bus.paddr   = paddr_i[`APB8_OFFS_W-1:0];
  assign gpio_bus.pwdata  = pwdata_i;

  assign uart_bus.psel    = psel_i & (region == REGION_UART);
  assign uart_bus.penable = penable_i;
  assign uart_bus.pwrite  = wr_qual;
  assign uart_bus.paddr   = paddr_i[`APB8_OFFS_W-1:0];
  assign uart_bus.pwdata  = pwdata_i;

  ////////////////////////////////////////////////////////////
  // Error responder
  ////////////////////////////////////////////////////////////

  // Armed in the setup cycle, answers in the first access cycle
  always_ff @(posedge PCLK) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= psel_i & ~penable_i & (region == REGION_NONE);
    end
  end

  // Response mux
  always_comb begin
    case (region)
      REGION_GPIO: begin
        prdata_o  = gpio_bus.prdata;
        pready_o  = gpio_bus.pready;
        pslverr_o = gpio_bus.pslverr;
      end
      REGION_UART: begin
        prdata_o  = uart_bus.prdata;
        pready_o  = uart_bus.pready;
        pslverr_o = uart_bus.pslverr;
      end
      default: begin
        // Unmapped, read data is always zero
        prdata_o  = '0;
        pready_o  = err_q;
        pslverr_o = err_q;
      end
    endcase
  end

endmodule

// File: rtl/apb8_if.sv
// APB slave-side bus between the decoder and one peripheral
// Decoder modport drives the request, slave modport the response

`include "apb8_defs.svh"

interface apb8_if;

  // Request, from the decoder
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`APB8_OFFS_W-1:0] paddr;
  logic [`APB8_DATA_W-1:0] pwdata;

  // Response, from the slave
  logic [`APB8_DATA_W-1:0] prdata;
  logic                    pready;
  logic                    pslverr;

  modport dec (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  modport slv (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

// File: rtl/apb8_pkg.sv
// Shared types of the APB peripheral subsystem
// Address region enum produced by the decoder
// GPIO and UART register offsets
// UART status word layout

package apb8_pkg;

  ////////////////////////////////////////////////////////////
  // Address regions
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    REGION_GPIO = 2'd0,
    REGION_UART = 2'd1,
    REGION_NONE = 2'd2
  } apb8_region_e;

  ////////////////////////////////////////////////////////////
  // Register offsets
  ////////////////////////////////////////////////////////////

  // GPIO, repeats every 4 bytes in its window
  typedef enum logic [1:0] {
    GPIO_IN  = 2'd0,
    GPIO_OUT = 2'd1,
    GPIO_OE  = 2'd2,
    GPIO_IRQ = 2'd3
  } gpio_reg_e;

  // UART, offsets 4 to 7 are unmapped
  typedef enum logic [2:0] {
    UART_DATA   = 3'd0,
    UART_STATUS = 3'd1,
    UART_DIV    = 3'd2,
    UART_CTRL   = 3'd3
  } uart_reg_e;

  // Status bits, holding_full is bit 0
  typedef struct packed {
    logic irq;
    logic busy;
    logic holding_full;
  } uart_status_t;

endpackage

// File: rtl/apb8_slaves.sv
// Top level of the 8-bit APB peripheral subsystem
// Decoder, GPIO port and UART transmitter wired together
// Plain APB4 ports toward the system bus

`include "apb8_defs.svh"

module apb8_slaves (
  input  logic                    PCLK,
  input  logic                    reset_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`APB8_ADDR_W-1:0] paddr_i,
  input  logic [`APB8_DATA_W-1:0] pwdata_i,
  input  logic [`APB8_STRB_W-1:0] pstrb_i,
  output logic [`APB8_DATA_W-1:0] prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  input  logic [`APB8_DATA_W-1:0] gpio_i,
  output logic [`APB8_DATA_W-1:0] gpio_o,
  output logic [`APB8_DATA_W-1:0] gpio_oe_o,
  output logic                    gpio_int_o,
  output logic                    uart_txd_o,
  output logic                    uart_int_o
);

  // UART internal links
  logic                    tx_valid;
  logic                    tx_ready;
  logic [`APB8_DATA_W-1:0] tx_data;
  logic [`APB8_DATA_W-1:0] div;
  logic                    busy;
  logic                    run;
  logic                    tick;

  ////////////////////////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////////////////////////

  apb8_if gpio_bus ();
  apb8_if uart_bus ();

  apb8_decoder u_decoder (
    .PCLK     (PCLK),
    .reset_i  (reset_i),
    .psel_i   (psel_i),
    .penable_i(penable_i),
    .pwrite_i (pwrite_i),
    .paddr_i  (paddr_i),
    .pwdata_i (pwdata_i),
    .pstrb_i  (pstrb_i),
    .prdata_o (prdata_o),
    .pready_o (pready_o),
    .pslverr_o(pslverr_o),
    .gpio_bus (gpio_bus.dec),
    .uart_bus (uart_bus.dec)
  );

  ////////////////////////////////////////////////////////////
  // Peripherals
  ////////////////////////////////////////////////////////////

  gpio_port u_gpio (
    .PCLK      (PCLK),
    .reset_i   (reset_i),
    .bus       (gpio_bus.slv),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .gpio_int_o(gpio_int_o)
  );

  uart_tx_regs u_uart_regs (
    .PCLK      (PCLK),
    .reset_i   (reset_i),
    .bus       (uart_bus.slv),
    .tx_valid_o(tx_valid),
    .tx_data_o (tx_data),
    .tx_ready_i(tx_ready),
    .busy_i    (busy),
    .div_o     (div),
    .uart_int_o(uart_int_o)
  );

  uart_baud_timer u_baud (
    .PCLK   (PCLK),
    .reset_i(reset_i),
    .run_i  (run),
    .div_i  (div),
    .tick_o (tick)
  );

  uart_tx_fsm u_tx_fsm (
    .PCLK      (PCLK),
    .reset_i   (reset_i),
    .tx_valid_i(tx_valid),
    .tx_data_i (tx_data),
    .tx_ready_o(tx_ready),
    .tick_i    (tick),
    .run_o     (run),
    .busy_o    (busy),
    .txd_o     (uart_txd_o)
  );

endmodule

// File: rtl/gpio_port.sv
// 8-pin GPIO port on the APB bus
// Output data, output enable and pending interrupt registers
// Two-flop input synchronizer with rising-edge interrupt detect

`include "apb8_defs.svh"

module gpio_port (
  input  logic                    PCLK,
  input  logic                    reset_i,
  apb8_if.slv                     bus,
  input  logic [`APB8_DATA_W-1:0] gpio_i,
  output logic [`APB8_DATA_W-1:0] gpio_o,
  output logic [`APB8_DATA_W-1:0] gpio_oe_o,
  output logic                    gpio_int_o
);
  import apb8_pkg::*;

  gpio_reg_e               offs;
  logic                    wr;
  logic [`APB8_DATA_W-1:0] sync1_q;
  logic [`APB8_DATA_W-1:0] sync2_q;
  logic [`APB8_DATA_W-1:0] prev_q;
  logic [`APB8_DATA_W-1:0] rise;
  logic [`APB8_DATA_W-1:0] clr;
  logic [`APB8_DATA_W-1:0] irq_q;

  // Low two bits pick the register, the rest of the window aliases
  assign offs = gpio_reg_e'(bus.paddr[1:0]);

  // No wait states and no error responses
  assign bus.pready  = bus.psel & bus.penable;
  assign bus.pslverr = 1'b0;
  assign wr          = bus.pready & bus.pwrite;

  ////////////////////////////////////////////////////////////
  // Pin synchronizer and edge detect
  ////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (reset_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  // Low to high on the synchronized pin
  assign rise = sync2_q & ~prev_q;

  // Write-one-to-clear mask
  assign clr = (wr && offs == GPIO_IRQ) ? bus.pwdata : '0;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (reset_i) begin
      gpio_o    <= `APB8_GPIO_RST;
      gpio_oe_o <= `APB8_GPIO_RST;
      irq_q     <= '0;
    end else begin
      if (wr && offs == GPIO_OUT) begin
        gpio_o <= bus.pwdata;
      end
      if (wr && offs == GPIO_OE) begin
        gpio_oe_o <= bus.pwdata;
      end
      // New edge wins over a clear in the same cycle
      irq_q <= (irq_q & ~clr) | rise;
    end
  end

  assign gpio_int_o = |irq_q;

  // Read mux
  always_comb begin
    case (offs)
      GPIO_IN:  bus.prdata = sync2_q;
      GPIO_OUT: bus.prdata = gpio_o;
      GPIO_OE:  bus.prdata = gpio_oe_o;
      default:  bus.prdata = irq_q;
    endcase
  end

endmodule

// File: rtl/uart_baud_timer.sv
// UART bit-period timer
// Down-counter giving one tick per divisor count of cycles

`include "apb8_defs.svh"

module uart_baud_timer (
  input  logic                    PCLK,
  input  logic                    reset_i,
  input  logic                    run_i,
  input  logic [`APB8_DATA_W-1:0] div_i,
  output logic                    tick_o
);

  logic [`APB8_DATA_W-1:0] cnt_q;
  logic [`APB8_DATA_W-1:0] div_q;

  // Last count of a bit period, zero divisor acts as one
  assign tick_o = run_i & (cnt_q <= 8'd1);

  always_ff @(posedge PCLK) begin
    if (reset_i) begin
      cnt_q <= `APB8_UART_DIV_RST;
      div_q <= `APB8_UART_DIV_RST;
    end else if (!run_i) begin
      // Idle, track the register so a frame starts with it
      cnt_q <= div_i;
      div_q <= div_i;
    end else if (tick_o) begin
      cnt_q <= div_q;
    end else begin
      cnt_q <= cnt_q - 8'd1;
    end
  end

endmodule

// File: rtl/uart_tx_fsm.sv
// UART transmit FSM for 8N1 frames
// Shift register and bit counter driving the serial line
// Consumer side of the valid/ready handshake

`include "apb8_defs.svh"

module uart_tx_fsm (
  input  logic                    PCLK,
  input  logic                    reset_i,
  input  logic                    tx_valid_i,
  input  logic [`APB8_DATA_W-1:0] tx_data_i,
  output logic                    tx_ready_o,
  input  logic                    tick_i,
  output logic                    run_o,
  output logic                    busy_o,
  output logic                    txd_o
);

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    START = 2'd1,
    DATA  = 2'd2,
    STOP  = 2'd3
  } state_e;

  state_e                  state_q;
  logic [2:0]              bit_cnt_q;
  logic [`APB8_DATA_W-1:0] shift_q;

  ////////////////////////////////////////////////////////////
  // Frame sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (reset_i) begin
      state_q   <= IDLE;
      bit_cnt_q <= 3'd0;
    end else begin
      case (state_q)
        IDLE: begin
          // Byte accepted on the handshake edge
          if (tx_valid_i) begin
            state_q <= START;
          end
        end
        START: begin
          if (tick_i) begin
            state_q   <= DATA;
            bit_cnt_q <= 3'd0;
          end
        end
        DATA: begin
          if (tick_i) begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            // Eighth data bit done
            if (bit_cnt_q == 3'd7) begin
              state_q <= STOP;
            end
          end
        end
        default: begin
          if (tick_i) begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  // Shift register, LSB goes out first
  always_ff @(posedge PCLK) begin
    if (tx_valid_i && tx_ready_o) begin
      shift_q <= tx_data_i;
    end else if (state_q == DATA && tick_i) begin
      shift_q <= shift_q >> 1;
    end
  end

  assign tx_ready_o = (state_q == IDLE);
  assign run_o      = (state_q != IDLE);
  assign busy_o     = run_o;

  // Line level per state, high when idle
  always_comb begin
    case (state_q)
      START:   txd_o = 1'b0;
      DATA:    txd_o = shift_q[0];
      default: txd_o = 1'b1;
    endcase
  end

endmodule

// File: rtl/uart_tx_regs.sv
// UART transmitter register block on the APB bus
// Divisor, control and holding register
// Valid/ready producer toward the transmit FSM

`include "apb8_defs.svh"

module uart_tx_regs (
  input  logic                    PCLK,
  input  logic                    reset_i,
  apb8_if.slv                     bus,
  output logic                    tx_valid_o,
  output logic [`APB8_DATA_W-1:0] tx_data_o,
  input  logic                    tx_ready_i,
  input  logic                    busy_i,
  output logic [`APB8_DATA_W-1:0] div_o,
  output logic                    uart_int_o
);
  import apb8_pkg::*;

  uart_reg_e    offs;
  uart_status_t status;
  logic         access;
  logic         data_wr;
  logic         wr_done;
  logic         ie_q;
  logic         hold_full_q;

  assign offs   = uart_reg_e'(bus.paddr);
  assign access = bus.psel & bus.penable;

  // Data write against a full holding register waits for the FSM
  assign data_wr     = access & bus.pwrite & (offs == UART_DATA);
  assign bus.pready  = access & ~(data_wr & hold_full_q & ~tx_ready_i);
  // Upper half of the window is unmapped
  assign bus.pslverr = access & bus.paddr[2];
  assign wr_done     = bus.pready & bus.pwrite;

  always_ff @(posedge PCLK) begin
    if (reset_i) begin
      div_o       <= `APB8_UART_DIV_RST;
      ie_q        <= 1'b0;
      hold_full_q <= 1'b0;
    end else begin
      if (wr_done && offs == UART_DIV) begin
        div_o <= bus.pwdata;
      end
      if (wr_done && offs == UART_CTRL) begin
        ie_q <= bus.pwdata[0];
      end
      // Refill and handover may share an edge, refill wins
      if (wr_done && offs == UART_DATA) begin
        hold_full_q <= 1'b1;
      end else if (tx_valid_o && tx_ready_i) begin
        hold_full_q <= 1'b0;
      end
    end
  end

  // Holding register payload
  always_ff @(posedge PCLK) begin
    if (wr_done && offs == UART_DATA) begin
      tx_data_o <= bus.pwdata;
    end
  end

  assign tx_valid_o = hold_full_q;
  assign uart_int_o = ie_q & ~hold_full_q;

  assign status.irq          = uart_int_o;
  assign status.busy         = busy_i;
  assign status.holding_full = hold_full_q;

  // Read mux, DATA reads as zero
  always_comb begin
    bus.prdata = '0;
    case (offs)
      UART_STATUS: bus.prdata[2:0] = status;
      UART_DIV:    bus.prdata = div_o;
      UART_CTRL:   bus.prdata[0] = ie_q;
      default:     bus.prdata = '0;
    endcase
  end

endmodule

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_apb8_slaves \
  -o tb_apb8_slaves > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/tb_apb8_slaves > sim.log 2>&1 ; cat sim.log

grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// File: test/tb_apb8_slaves.sv
// Testbench for the 8-bit APB peripheral subsystem
// Clock, reset, APB read and write tasks with pready wait
// UART line monitor feeding a received-byte check
// Concurrent assertions on read data, errors, pins and frames
// Per-test report lines, closing counts and cycle timeout

`include "apb8_defs.svh"

module tb_apb8_slaves;
  import apb8_pkg::*;

  localparam int SEED         = 32'h2566_eb6b;
  localparam int FRAME_CYCLES = 10 * int'(`APB8_UART_DIV_RST);
  // Six frames, the register tests and a wide margin
  localparam int MAX_CYCLES   = 6 * FRAME_CYCLES + 3040;
  localparam logic [7:0] ERR_ADDRS [7] = '{8'h18, 8'h80, 8'hff, 8'h14, 8'h15, 8'h16, 8'h17};

  logic                    PCLK;
  logic                    reset_i;
  logic                    psel_i;
  logic                    penable_i;
  logic                    pwrite_i;
  logic [`APB8_ADDR_W-1:0] paddr_i;
  logic [`APB8_DATA_W-1:0] pwdata_i;
  logic [`APB8_STRB_W-1:0] pstrb_i;
  logic [`APB8_DATA_W-1:0] prdata_o;
  logic                    pready_o;
  logic                    pslverr_o;
  logic [`APB8_DATA_W-1:0] gpio_i;
  logic [`APB8_DATA_W-1:0] gpio_o;
  logic [`APB8_DATA_W-1:0] gpio_oe_o;
  logic                    gpio_int_o;
  logic                    uart_txd_o;
  logic                    uart_int_o;

  // Bookkeeping
  int         err_cnt = 0;
  int         chk_cnt = 0;
  int         test_cnt = 0;
  int         test_err0 = 0;
  int         cycle_cnt = 0;
  int         last_waits;
  int         rx_cnt = 0;
  int         tb_div;

  // Check enables and expected values
  logic       rd_chk;
  logic [7:0] exp_rdata;
  logic       exp_err;
  logic       rst_chk;
  logic       line_chk;
  logic       pins_chk;
  logic [7:0] exp_out;
  logic [7:0] exp_oe;
  logic       gint_chk;
  logic       exp_gint;
  logic       uint_chk;
  logic       exp_uint;
  logic       stall_chk;
  logic       rx_strobe;
  logic       rx_framed;
  logic [7:0] rx_byte;
  logic [7:0] rx_expect;
  logic [7:0] sent_q[$];

  apb8_slaves dut (.*);

  initial begin
    PCLK = 1'b0;
    forever #10 PCLK = ~PCLK;
  end

  always @(posedge PCLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Address map model and helpers
  ////////////////////////////////////////////////////////////

  function automatic apb8_region_e region_of(logic [7:0] addr);
    logic [7:0]   gpio_off;
    logic [7:0]   uart_off;
    apb8_region_e region;
    gpio_off = addr - `APB8_GPIO_BASE;
    uart_off = addr - `APB8_UART_BASE;
    region   = REGION_NONE;
    if (gpio_off < `APB8_GPIO_SIZE) begin
      region = REGION_GPIO;
    end else if (uart_off < `APB8_UART_SIZE) begin
      region = REGION_UART;
    end
    return region;
  endfunction

  // Unmapped space and UART offsets 4 to 7 answer with an error
  function automatic logic is_error(logic [7:0] addr);
    logic [7:0] uart_off;
    logic       err;
    uart_off = addr - `APB8_UART_BASE;
    err      = 1'b0;
    if (region_of(addr) == REGION_NONE) begin
      err = 1'b1;
    end else if (region_of(addr) == REGION_UART) begin
      err = (uart_off > 8'd3);
    end
    return err;
  endfunction

  function automatic logic [7:0] gpio_addr(gpio_reg_e r);
    return `APB8_GPIO_BASE + {6'd0, r};
  endfunction

  function automatic logic [7:0] uart_addr(uart_reg_e r);
    return `APB8_UART_BASE + {5'd0, r};
  endfunction

  function automatic logic [7:0] status_word(logic irq, logic busy, logic full);
    uart_status_t st;
    st.irq          = irq;
    st.busy         = busy;
    st.holding_full = full;
    return {5'd0, st};
  endfunction

  assign exp_err = is_error(paddr_i);

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  a_rdata: assert property (@(posedge PCLK) disable iff (reset_i)
    (rd_chk && psel_i && penable_i && pready_o) |-> (prdata_o == exp_rdata))
    else report_mismatch($sformatf("read of %h gave %h, expected %h",
      $sampled(paddr_i), $sampled(prdata_o), exp_rdata));

  a_pslverr: assert property (@(posedge PCLK) disable iff (reset_i)
    (psel_i && penable_i && pready_o) |-> (pslverr_o == exp_err))
    else report_mismatch($sformatf("pslverr %b at address %h",
      $sampled(pslverr_o), $sampled(paddr_i)));

  a_reset: assert property (@(posedge PCLK) disable iff (reset_i)
    rst_chk |-> (gpio_o == 8'h00 && gpio_oe_o == 8'h00 && !gpio_int_o &&
                 !uart_int_o && !pready_o && !pslverr_o))
    else report_mismatch("control outputs active after reset");

  a_line_idle: assert property (@(posedge PCLK) disable iff (reset_i)
    line_chk |-> uart_txd_o)
    else report_mismatch("UART line not idle high");

  a_pins: assert property (@(posedge PCLK) disable iff (reset_i)
    pins_chk |-> (gpio_o == exp_out && gpio_oe_o == exp_oe))
    else report_mismatch($sformatf("gpio_o %h gpio_oe_o %h, expected %h %h",
      $sampled(gpio_o), $sampled(gpio_oe_o), exp_out, exp_oe));

  a_gpio_int: assert property (@(posedge PCLK) disable iff (reset_i)
    gint_chk |-> (gpio_int_o == exp_gint))
    else report_mismatch($sformatf("gpio_int_o expected %b", exp_gint));

  a_uart_int: assert property (@(posedge PCLK) disable iff (reset_i)
    (uint_chk && psel_i && penable_i && pready_o) |-> (uart_int_o == exp_uint))
    else report_mismatch($sformatf("uart_int_o expected %b", exp_uint));

  a_stall: assert property (@(posedge PCLK) disable iff (reset_i)
    stall_chk |-> (last_waits > 0))
    else report_failure("data write with a full holding register did not stall");

  a_rx_byte: assert property (@(posedge PCLK) disable iff (reset_i)
    rx_strobe |-> (rx_byte == rx_expect))
    else report_mismatch($sformatf("UART byte %h, expected %h", rx_byte, rx_expect));

  a_rx_frame: assert property (@(posedge PCLK) disable iff (reset_i)
    rx_strobe |-> rx_framed)
    else report_failure("UART frame had a bad start or stop bit");

  ////////////////////////////////////////////////////////////
  // Bus tasks, entered 2 units after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic cycles(input int n);
    repeat (n) @(posedge PCLK);
    #2;
  endtask

  // Setup cycle, then access cycles until pready, sampled mid-cycle
  task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                              input logic [7:0] wdata, input logic strb,
                              output logic [7:0] rdata, output int waits);
    logic ready;
    waits     = 0;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    pstrb_i   = strb;
    cycles(1);
    penable_i = 1'b1;
    do begin
      @(negedge PCLK);
      ready = pready_o;
      rdata = prdata_o;
      if (!ready) begin
        waits++;
      end
      @(posedge PCLK);
    end while (!ready);
    #2;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    logic [7:0] rdata;
    apb_transfer(1'b1, addr, data, 1'b1, rdata, last_waits);
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [7:0] exp);
    logic [7:0] rdata;
    int         waits;
    exp_rdata = exp;
    rd_chk    = 1'b1;
    chk_cnt++;
    apb_transfer(1'b0, addr, 8'h00, 1'b0, rdata, waits);
    rd_chk = 1'b0;
  endtask

  task automatic status_expect(input logic irq, input logic busy, input logic full);
    exp_uint = irq;
    uint_chk = 1'b1;
    read_expect(uart_addr(UART_STATUS), status_word(irq, busy, full));
    uint_chk = 1'b0;
  endtask

  task automatic expect_gpio_int(input logic level);
    exp_gint = level;
    gint_chk = 1'b1;
    chk_cnt++;
    cycles(1);
    gint_chk = 1'b0;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("Test %0d %s finished, %0d errors", test_cnt, name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////
  // UART line monitor
  ////////////////////////////////////////////////////////////

  initial begin : uart_monitor
    logic [7:0] data;
    logic       start_ok;
    #1;
    wait (reset_i == 1'b0);
    forever begin
      @(negedge uart_txd_o);
      // Mid start bit, then one bit period per sample
      repeat (tb_div / 2) @(negedge PCLK);
      start_ok = !uart_txd_o;
      for (int i = 0; i < 8; i++) begin
        repeat (tb_div) @(negedge PCLK);
        data[i] = uart_txd_o;
      end
      repeat (tb_div) @(negedge PCLK);
      if (sent_q.size() == 0) begin
        report_failure("UART byte received with nothing sent");
      end else begin
        rx_framed = start_ok & uart_txd_o;
        rx_byte   = data;
        rx_expect = sent_q.pop_front();
        rx_strobe = 1'b1;
        chk_cnt++;
      end
      rx_cnt++;
      @(negedge PCLK);
      rx_strobe = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic check_reset_values();
    rst_chk  = 1'b1;
    line_chk = 1'b1;
    chk_cnt++;
    cycles(3);
    rst_chk = 1'b0;
    read_expect(uart_addr(UART_DIV), `APB8_UART_DIV_RST);
    read_expect(uart_addr(UART_CTRL), 8'h00);
    status_expect(1'b0, 1'b0, 1'b0);
    read_expect(gpio_addr(GPIO_IRQ), 8'h00);
    end_test("reset values");
  endtask

  task automatic gpio_register_rw();
    logic [7:0] pins;
    logic [7:0] rdata;
    exp_out = 8'($urandom);
    exp_oe  = 8'($urandom);
    write_reg(gpio_addr(GPIO_OUT), exp_out);
    write_reg(gpio_addr(GPIO_OE), exp_oe);
    // Strobe low, data dropped
    apb_transfer(1'b1, gpio_addr(GPIO_OUT), ~exp_out, 1'b0, rdata, last_waits);
    pins_chk = 1'b1;
    chk_cnt++;
    read_expect(gpio_addr(GPIO_OUT), exp_out);
    read_expect(gpio_addr(GPIO_OE), exp_oe);
    pins_chk = 1'b0;
    pins     = 8'($urandom);
    gpio_i   = pins;
    cycles(1);
    read_expect(gpio_addr(GPIO_IN), pins);
    end_test("gpio registers");
  endtask

  task automatic gpio_edge_irq();
    gpio_i = 8'h00;
    cycles(4);
    write_reg(gpio_addr(GPIO_IRQ), 8'hff);
    read_expect(gpio_addr(GPIO_IRQ), 8'h00);
    expect_gpio_int(1'b0);
    // Rising edges on pins 3 and 5
    gpio_i = 8'h28;
    cycles(4);
    read_expect(gpio_addr(GPIO_IRQ), 8'h28);
    expect_gpio_int(1'b1);
    write_reg(gpio_addr(GPIO_IRQ), 8'h08);
    read_expect(gpio_addr(GPIO_IRQ), 8'h20);
    expect_gpio_int(1'b1);
    write_reg(gpio_addr(GPIO_IRQ), 8'h20);
    read_expect(gpio_addr(GPIO_IRQ), 8'h00);
    expect_gpio_int(1'b0);
    // Falling edges on cleared pins set nothing
    gpio_i = 8'h00;
    cycles(4);
    read_expect(gpio_addr(GPIO_IRQ), 8'h00);
    expect_gpio_int(1'b0);
    end_test("gpio interrupts");
  endtask

  task automatic unmapped_errors();
    foreach (ERR_ADDRS[i]) begin
      write_reg(ERR_ADDRS[i], 8'($urandom));
      read_expect(ERR_ADDRS[i], 8'h00);
    end
    // Error writes leave the GPIO alone
    read_expect(gpio_addr(GPIO_OUT), exp_out);
    end_test("error responses");
  endtask

  task automatic uart_back_to_back();
    logic [7:0] b;
    tb_div = int'(`APB8_UART_DIV_RST);
    write_reg(uart_addr(UART_DIV), 8'(tb_div));
    read_expect(uart_addr(UART_DIV), 8'(tb_div));
    line_chk = 1'b0;
    for (int i = 0; i < 4; i++) begin
      b = 8'($urandom);
      sent_q.push_back(b);
      write_reg(uart_addr(UART_DATA), b);
      // From the third byte on the holding register is full
      if (i >= 2) begin
        stall_chk = 1'b1;
        chk_cnt++;
        cycles(1);
        stall_chk = 1'b0;
      end
    end
    wait (rx_cnt == 4);
    cycles(tb_div);
    end_test("uart frames");
  endtask

  task automatic uart_status_irq();
    logic [7:0] b;
    write_reg(uart_addr(UART_CTRL), 8'h01);
    read_expect(uart_addr(UART_CTRL), 8'h01);
    status_expect(1'b1, 1'b0, 1'b0);
    b = 8'($urandom);
    sent_q.push_back(b);
    write_reg(uart_addr(UART_DATA), b);
    // FSM takes it at once
    status_expect(1'b1, 1'b1, 1'b0);
    b = 8'($urandom);
    sent_q.push_back(b);
    write_reg(uart_addr(UART_DATA), b);
    status_expect(1'b0, 1'b1, 1'b1);
    wait (rx_cnt == 6);
    cycles(tb_div);
    status_expect(1'b1, 1'b0, 1'b0);
    write_reg(uart_addr(UART_CTRL), 8'h00);
    end_test("uart status and interrupt");
  endtask

  initial begin
    void'($urandom(SEED));
    reset_i   = 1'b1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = 8'h00;
    pwdata_i  = 8'h00;
    pstrb_i   = '0;
    gpio_i    = 8'h00;
    rd_chk    = 1'b0;
    exp_rdata = 8'h00;
    rst_chk   = 1'b0;
    line_chk  = 1'b0;
    pins_chk  = 1'b0;
    exp_out   = 8'h00;
    exp_oe    = 8'h00;
    gint_chk  = 1'b0;
    exp_gint  = 1'b0;
    uint_chk  = 1'b0;
    exp_uint  = 1'b0;
    stall_chk = 1'b0;
    rx_strobe = 1'b0;
    rx_framed = 1'b0;
    rx_byte   = 8'h00;
    rx_expect = 8'h00;
    tb_div    = int'(`APB8_UART_DIV_RST);
    repeat (2) @(posedge PCLK);
    #2;
    reset_i = 1'b0;
    check_reset_values();
    gpio_register_rw();
    gpio_edge_irq();
    unmapped_errors();
    uart_back_to_back();
    uart_status_irq();
    $display("Tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
